// File: hdl/aib_cal_pkg.sv
/*
 * shared types for the master-side link bring-up controller
 * holds the request/status bundles and the state encodings of the
 * three sequences, modules pull them in with a wildcard import
 */
`default_nettype none

package aib_cal_pkg;

    // ========================================
    // defaults
    // ========================================
    localparam int DEF_SYNC_STAGES = 2; // flops per synchronizer

    // ========================================
    // request and status bundles
    // ========================================
    // asynchronous inputs, the synchronized copy uses the same type
    typedef struct packed {
        logic config_done;        // local configuration complete
        logic remote_osc_xfer_en; // remote confirms osc transfer
        logic remote_tx_lock_req; // rx calibration requests
        logic local_rx_lock_req;
        logic local_rx_dll_lock;  // local rx dll locked
        logic remote_tx_cal_done; // remote tx dcc done
        logic remote_rx_lock_req; // tx calibration requests
        logic local_tx_lock_req;
        logic local_tx_cal_done;  // local tx dcc done
        logic remote_rx_dll_lock;
        logic remote_rx_xfer_en;
    } cal_req_t;

    typedef struct packed {
        logic osc_xfer_en;
        logic osc_xfer_alive;
        logic rx_async_rst;       // high while rx sequence is active
        logic rx_dll_lock_req;
        logic rx_dll_lock;
        logic rx_xfer_en;
        logic tx_async_rst;       // high while tx sequence is active
        logic tx_dcc_cal_req;
        logic tx_dcc_cal_done;
        logic tx_xfer_en;
    } cal_status_t;

    // ========================================
    // sequence states
    // ========================================
    typedef enum logic [1:0] {
        OSC_WAIT    = 2'd0,
        OSC_XFER_EN = 2'd1,
        OSC_ALIVE   = 2'd2
    } osc_state_t;

    // remote tx to local rx
    typedef enum logic [2:0] {
        RX_WAIT            = 3'd0,
        RX_WAIT_REMOTE_CAL = 3'd1,
        RX_LOCK_REQ        = 3'd2,
        RX_LOCKED          = 3'd3,
        RX_XFER_EN         = 3'd4
    } rx_cal_state_t;

    // local tx to remote rx
    typedef enum logic [2:0] {
        TX_WAIT             = 3'd0,
        TX_CAL_REQ          = 3'd1,
        TX_WAIT_REMOTE_LOCK = 3'd2,
        TX_WAIT_REMOTE_XFER = 3'd3,
        TX_XFER_EN          = 3'd4
    } tx_cal_state_t;

endpackage

`default_nettype wire

// File: hdl/aib_input_sync.sv
/*
 * synchronizer bank for every asynchronous request and status input
 * each bit runs through SYNC_STAGES reset-to-zero flops on osc_clk
 */
`timescale 1ns/100ps
`default_nettype none

module aib_input_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                  osc_clk,
    input  logic                  ms_reset_n_sync,
    input  aib_cal_pkg::cal_req_t i_req,
    output aib_cal_pkg::cal_req_t o_req_sync
);

    import aib_cal_pkg::*;

    // stage 0 samples the async input, last stage is the safe copy
    cal_req_t sync_q [SYNC_STAGES];

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= i_req; // metastable stage
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign o_req_sync = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: hdl/aib_osc_sync_fsm.sv
/*
 * oscillator transfer bring-up sequence
 * enables the transfer once configured, goes alive when the remote end
 * confirms, and falls back to wait whenever config_done drops
 */
`timescale 1ns/100ps
`default_nettype none

module aib_osc_sync_fsm (
    input  logic                    osc_clk,
    input  logic                    ms_reset_n_sync,
    input  aib_cal_pkg::cal_req_t   i_req_sync,
    output aib_cal_pkg::osc_state_t o_osc_state,
    output logic                    o_osc_alive
);

    import aib_cal_pkg::*;

    osc_state_t osc_q;
    osc_state_t osc_next;

    always_comb begin
        osc_next = osc_q;
        if (!i_req_sync.config_done) begin
            osc_next = OSC_WAIT; // config lost, start over
        end else begin
            case (osc_q)
                OSC_WAIT: begin
                    osc_next = OSC_XFER_EN;
                end
                OSC_XFER_EN: begin
                    if (i_req_sync.remote_osc_xfer_en) begin
                        osc_next = OSC_ALIVE;
                    end
                end
                OSC_ALIVE: begin
                    osc_next = OSC_ALIVE;
                end
                default: begin
                    osc_next = OSC_WAIT;
                end
            endcase
        end
    end

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            osc_q <= OSC_WAIT;
        end else begin
            osc_q <= osc_next;
        end
    end

    assign o_osc_state = osc_q;
    assign o_osc_alive = (osc_q == OSC_ALIVE); // gates both calibrations

endmodule

`default_nettype wire

// File: hdl/aib_rx_cal_fsm.sv
/*
 * receive calibration sequence, remote tx to local rx
 * waits for the remote dcc calibration, requests the local dll lock and
 * then enables receive transfer, either request dropping aborts it
 */
`timescale 1ns/100ps
`default_nettype none

module aib_rx_cal_fsm (
    input  logic                       osc_clk,
    input  logic                       ms_reset_n_sync,
    input  aib_cal_pkg::cal_req_t      i_req_sync,
    input  logic                       i_osc_alive,
    output aib_cal_pkg::rx_cal_state_t o_rx_state
);

    import aib_cal_pkg::*;

    rx_cal_state_t rx_q;
    rx_cal_state_t rx_next;
    logic          req_any;  // one side asks to start
    logic          req_both; // both sides still asking
    logic          rx_start;

    assign req_any  = i_req_sync.remote_tx_lock_req | i_req_sync.local_rx_lock_req;
    assign req_both = i_req_sync.remote_tx_lock_req & i_req_sync.local_rx_lock_req;
    assign rx_start = i_req_sync.config_done & i_osc_alive & req_any;

    always_comb begin
        rx_next = rx_q;
        case (rx_q)
            RX_WAIT: begin
                if (rx_start) begin
                    rx_next = RX_WAIT_REMOTE_CAL;
                end
            end
            RX_WAIT_REMOTE_CAL: begin
                if (!req_both) begin
                    rx_next = RX_WAIT;
                end else if (i_req_sync.remote_tx_cal_done) begin
                    rx_next = RX_LOCK_REQ;
                end
            end
            RX_LOCK_REQ: begin
                if (!req_both) begin
                    rx_next = RX_WAIT;
                end else if (i_req_sync.local_rx_dll_lock) begin
                    rx_next = RX_LOCKED;
                end
            end
            RX_LOCKED: begin
                if (!req_both) begin
                    rx_next = RX_WAIT;
                end else begin
                    rx_next = RX_XFER_EN; // one cycle in locked
                end
            end
            RX_XFER_EN: begin
                if (!req_both) begin
                    rx_next = RX_WAIT;
                end
            end
            default: begin
                rx_next = RX_WAIT;
            end
        endcase
    end

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            rx_q <= RX_WAIT;
        end else begin
            rx_q <= rx_next;
        end
    end

    assign o_rx_state = rx_q;

endmodule

`default_nettype wire

// File: hdl/aib_tx_cal_fsm.sv
/*
 * transmit calibration sequence, local tx to remote rx
 * requests the local dcc calibration, then waits for the remote dll lock
 * and the remote receive enable, a dropped request aborts it
 */
`timescale 1ns/100ps
`default_nettype none

module aib_tx_cal_fsm (
    input  logic                       osc_clk,
    input  logic                       ms_reset_n_sync,
    input  aib_cal_pkg::cal_req_t      i_req_sync,
    input  logic                       i_osc_alive,
    output aib_cal_pkg::tx_cal_state_t o_tx_state
);

    import aib_cal_pkg::*;

    tx_cal_state_t tx_q;
    tx_cal_state_t tx_next;
    logic          req_both; // start and stay need both requests
    logic          tx_start;

    assign req_both = i_req_sync.remote_rx_lock_req & i_req_sync.local_tx_lock_req;
    assign tx_start = i_req_sync.config_done & i_osc_alive & req_both;

    always_comb begin
        tx_next = tx_q;
        case (tx_q)
            TX_WAIT: begin
                if (tx_start) begin
                    tx_next = TX_CAL_REQ;
                end
            end
            TX_CAL_REQ: begin
                if (!req_both) begin
                    tx_next = TX_WAIT;
                end else if (i_req_sync.local_tx_cal_done) begin
                    tx_next = TX_WAIT_REMOTE_LOCK;
                end
            end
            TX_WAIT_REMOTE_LOCK: begin
                if (!req_both) begin
                    tx_next = TX_WAIT;
                end else if (i_req_sync.remote_rx_dll_lock) begin
                    tx_next = TX_WAIT_REMOTE_XFER;
                end
            end
            TX_WAIT_REMOTE_XFER: begin
                if (!req_both) begin
                    tx_next = TX_WAIT;
                end else if (i_req_sync.remote_rx_xfer_en) begin
                    tx_next = TX_XFER_EN;
                end
            end
            TX_XFER_EN: begin
                if (!req_both) begin
                    tx_next = TX_WAIT;
                end
            end
            default: begin
                tx_next = TX_WAIT;
            end
        endcase
    end

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            tx_q <= TX_WAIT;
        end else begin
            tx_q <= tx_next;
        end
    end

    assign o_tx_state = tx_q;

endmodule

`default_nettype wire

// File: hdl/aib_status_reg.sv
/*
 * registered status flags decoded from the three sequence states
 * a flag sets in its own state, clears in the wait state, holds otherwise
 */
`timescale 1ns/100ps
`default_nettype none

module aib_status_reg (
    input  logic                       osc_clk,
    input  logic                       ms_reset_n_sync,
    input  aib_cal_pkg::osc_state_t    i_osc_state,
    input  aib_cal_pkg::rx_cal_state_t i_rx_state,
    input  aib_cal_pkg::tx_cal_state_t i_tx_state,
    output aib_cal_pkg::cal_status_t   o_status
);

    import aib_cal_pkg::*;

    cal_status_t status_q;
    cal_status_t status_next;
    logic        osc_idle;
    logic        rx_idle;
    logic        tx_idle;

    function automatic logic hold_flag(input logic set_c, input logic clr_c, input logic cur);
        logic nxt;
        if (set_c) begin
            nxt = 1'b1;
        end else if (clr_c) begin
            nxt = 1'b0;
        end else begin
            nxt = cur;
        end
        return nxt;
    endfunction

    assign osc_idle = (i_osc_state == OSC_WAIT);
    assign rx_idle  = (i_rx_state == RX_WAIT);
    assign tx_idle  = (i_tx_state == TX_WAIT);

    // ========================================
    // next flag values
    // ========================================
    always_comb begin
        status_next.osc_xfer_en     = hold_flag(i_osc_state == OSC_XFER_EN, osc_idle,
                                                status_q.osc_xfer_en);
        status_next.osc_xfer_alive  = hold_flag(i_osc_state == OSC_ALIVE, osc_idle,
                                                status_q.osc_xfer_alive);
        status_next.rx_async_rst    = !rx_idle; // whole active span
        status_next.rx_dll_lock_req = hold_flag(i_rx_state == RX_LOCK_REQ, rx_idle,
                                                status_q.rx_dll_lock_req);
        status_next.rx_dll_lock     = hold_flag(i_rx_state == RX_LOCKED, rx_idle,
                                                status_q.rx_dll_lock);
        status_next.rx_xfer_en      = hold_flag(i_rx_state == RX_XFER_EN, rx_idle,
                                                status_q.rx_xfer_en);
        status_next.tx_async_rst    = !tx_idle;
        status_next.tx_dcc_cal_req  = hold_flag(i_tx_state == TX_CAL_REQ, tx_idle,
                                                status_q.tx_dcc_cal_req);
        status_next.tx_dcc_cal_done = hold_flag(i_tx_state == TX_WAIT_REMOTE_LOCK, tx_idle,
                                                status_q.tx_dcc_cal_done);
        status_next.tx_xfer_en      = hold_flag(i_tx_state == TX_XFER_EN, tx_idle,
                                                status_q.tx_xfer_en);
    end

    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            status_q <= '0;
        end else begin
            status_q <= status_next;
        end
    end

    assign o_status = status_q;

endmodule

`default_nettype wire

// File: hdl/aib_cal_top.sv
/*
 * master-side link bring-up controller
 * synchronizer bank, oscillator/rx/tx sequences and the status register
 * an input change shows on o_status SYNC_STAGES+2 cycles later
 */
`timescale 1ns/100ps
`default_nettype none

module aib_cal_top #(
    parameter int SYNC_STAGES = aib_cal_pkg::DEF_SYNC_STAGES
) (
    input  logic                     osc_clk,
    input  logic                     ms_reset_n_sync, // already synchronized
    input  aib_cal_pkg::cal_req_t    i_req,
    output aib_cal_pkg::cal_status_t o_status
);

    import aib_cal_pkg::*;

    cal_req_t      req_sync;
    osc_state_t    osc_state;
    logic          osc_alive;
    rx_cal_state_t rx_state;
    tx_cal_state_t tx_state;

    // ========================================
    // input side
    // ========================================
    aib_input_sync #(
        .SYNC_STAGES    (SYNC_STAGES)
    ) aib_input_sync_inst (
        .osc_clk        (osc_clk),
        .ms_reset_n_sync(ms_reset_n_sync),
        .i_req          (i_req),
        .o_req_sync     (req_sync)
    );

    // ========================================
    // sequences
    // ========================================
    aib_osc_sync_fsm aib_osc_sync_fsm_inst (
        .osc_clk        (osc_clk),
        .ms_reset_n_sync(ms_reset_n_sync),
        .i_req_sync     (req_sync),
        .o_osc_state    (osc_state),
        .o_osc_alive    (osc_alive)
    );

    aib_rx_cal_fsm aib_rx_cal_fsm_inst (
        .osc_clk        (osc_clk),
        .ms_reset_n_sync(ms_reset_n_sync),
        .i_req_sync     (req_sync),
        .i_osc_alive    (osc_alive),
        .o_rx_state     (rx_state)
    );

    aib_tx_cal_fsm aib_tx_cal_fsm_inst (
        .osc_clk        (osc_clk),
        .ms_reset_n_sync(ms_reset_n_sync),
        .i_req_sync     (req_sync),
        .i_osc_alive    (osc_alive),
        .o_tx_state     (tx_state)
    );

    // ========================================
    // output side
    // ========================================
    aib_status_reg aib_status_reg_inst (
        .osc_clk        (osc_clk),
        .ms_reset_n_sync(ms_reset_n_sync),
        .i_osc_state    (osc_state),
        .i_rx_state     (rx_state),
        .i_tx_state     (tx_state),
        .o_status       (o_status)
    );

endmodule

`default_nettype wire

// File: dv/aib_cal_asserts.sv
/*
 * concurrent checks on the status outputs of the bring-up controller
 * bound into aib_cal_top, flags that depend on an earlier flag must
 * never be seen without it
 */
`timescale 1ns/100ps
`default_nettype none

module aib_cal_asserts (
    input logic                     osc_clk,
    input logic                     ms_reset_n_sync,
    input aib_cal_pkg::cal_status_t i_status
);

    rx_xfer_needs_lock: assert property (@(posedge osc_clk) disable iff (!ms_reset_n_sync)
        i_status.rx_xfer_en |-> i_status.rx_dll_lock)
        else $error("rx_xfer_en is high while rx_dll_lock is low");

    tx_xfer_needs_cal: assert property (@(posedge osc_clk) disable iff (!ms_reset_n_sync)
        i_status.tx_xfer_en |-> i_status.tx_dcc_cal_done)
        else $error("tx_xfer_en is high while tx_dcc_cal_done is low");

    alive_needs_xfer: assert property (@(posedge osc_clk) disable iff (!ms_reset_n_sync)
        i_status.osc_xfer_alive |-> i_status.osc_xfer_en)
        else $error("osc_xfer_alive is high while osc_xfer_en is low");

    // lock is only reached through the lock request state
    lock_needs_lock_req: assert property (@(posedge osc_clk) disable iff (!ms_reset_n_sync)
        i_status.rx_dll_lock |-> i_status.rx_dll_lock_req)
        else $error("rx_dll_lock is high while rx_dll_lock_req is low");

endmodule

bind aib_cal_top aib_cal_asserts aib_cal_asserts_inst (
    .osc_clk        (osc_clk),
    .ms_reset_n_sync(ms_reset_n_sync),
    .i_status       (o_status)
);

`default_nettype wire

// File: dv/aib_cal_clk_gen.sv
/*
 * free-running testbench clock
 * starts low and toggles every half period
 */
`timescale 1ns/100ps
`default_nettype none

module aib_cal_clk_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk; // 50% duty

endmodule

`default_nettype wire

// File: dv/aib_cal_tb.sv
/*
 * directed testbench for the master-side bring-up controller
 * walks reset, osc bring-up, rx and tx calibration, abort and config loss
 * expected flags are kept in exp_st and compared bit by bit each step
 */
`timescale 1ns/100ps
`default_nettype none

module aib_cal_tb;

    import aib_cal_pkg::*;

    localparam int CLK_PERIOD_NS = 8;
    localparam int RESET_CYCLES  = 8;
    localparam int WAIT_LIMIT    = 20;  // bounded wait per flag
    localparam int N_TESTS       = 6;
    localparam int CYC_PER_TEST  = 400;
    localparam int WATCHDOG_NS   = N_TESTS * CYC_PER_TEST * CLK_PERIOD_NS;
    localparam logic [31:0] SEED = 32'h82b7_207b;

    logic        osc_clk;
    logic        ms_reset_n_sync;
    cal_req_t    req_drv;
    cal_status_t status_mon;
    cal_status_t exp_st;    // model of the flags
    int          err_cnt;
    int          chk_cnt;
    logic [31:0] rng_state;

    aib_cal_clk_gen #(
        .PERIOD_NS(CLK_PERIOD_NS)
    ) aib_cal_clk_gen_inst (
        .o_clk(osc_clk)
    );

    aib_cal_top #(
        .SYNC_STAGES    (DEF_SYNC_STAGES)
    ) aib_cal_top_inst (
        .osc_clk        (osc_clk),
        .ms_reset_n_sync(ms_reset_n_sync),
        .i_req          (req_drv),
        .o_status       (status_mon)
    );

    // ========================================
    // helpers
    // ========================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string flag_name(input int idx);
        case (idx)
            9: return "osc_xfer_en";
            8: return "osc_xfer_alive";
            7: return "rx_async_rst";
            6: return "rx_dll_lock_req";
            5: return "rx_dll_lock";
            4: return "rx_xfer_en";
            3: return "tx_async_rst";
            2: return "tx_dcc_cal_req";
            1: return "tx_dcc_cal_done";
            default: return "tx_xfer_en";
        endcase
    endfunction

    // 0 to 7 idle cycles, then land 1 ns after a rising edge
    task automatic next_drive_slot();
        int gap;
        rng_state = xorshift32(rng_state);
        gap = int'(rng_state[2:0]);
        repeat (gap) @(posedge osc_clk);
        @(posedge osc_clk);
        #1;
    endtask

    task automatic compare_flags(input string what);
        logic [9:0] got_v;
        logic [9:0] exp_v;
        got_v = status_mon;
        exp_v = exp_st;
        for (int i = 0; i < 10; i++) begin
            chk_cnt++;
            assert (got_v[i[3:0]] === exp_v[i[3:0]]) else begin
                $display("ERR %0t %s: got %b expected %b (%s)", $time, flag_name(i),
                         got_v[i[3:0]], exp_v[i[3:0]], what);
                err_cnt++;
            end
        end
    endtask

    // poll once per cycle until the flags match the model
    task automatic expect_status(input string what);
        int n;
        n = 0;
        @(posedge osc_clk);
        #1;
        while (status_mon !== exp_st && n < WAIT_LIMIT) begin
            @(posedge osc_clk);
            #1;
            n++;
        end
        assert (status_mon === exp_st) else begin
            $display("status did not settle within %0d cycles while waiting for %s",
                     WAIT_LIMIT, what);
            err_cnt++;
        end
        compare_flags(what);
    endtask

    task automatic hold_status(input int ncyc, input string what);
        repeat (ncyc) begin
            @(posedge osc_clk);
            #1;
            compare_flags(what);
        end
    endtask

    // ========================================
    // tests
    // ========================================
    task automatic test_reset();
        exp_st = '0;
        repeat (RESET_CYCLES / 2) @(posedge osc_clk);
        #1;
        compare_flags("during reset");
        repeat (RESET_CYCLES / 2) @(posedge osc_clk);
        #1;
        ms_reset_n_sync = 1'b1;
        hold_status(4, "after reset");
    endtask

    task automatic test_osc_bring_up();
        next_drive_slot();
        req_drv.config_done = 1'b1;
        exp_st.osc_xfer_en = 1'b1;
        expect_status("osc_xfer_en after config_done");
        hold_status(6, "osc waiting for remote"); // alive must stay low
        next_drive_slot();
        req_drv.remote_osc_xfer_en = 1'b1;
        exp_st.osc_xfer_alive = 1'b1;
        expect_status("osc_xfer_alive after remote_osc_xfer_en");
        hold_status(6, "osc alive steady");
    endtask

    task automatic test_rx_cal();
        next_drive_slot();
        req_drv.remote_tx_lock_req = 1'b1;
        req_drv.local_rx_lock_req  = 1'b1;
        exp_st.rx_async_rst = 1'b1;
        expect_status("rx_async_rst after rx requests");
        hold_status(6, "rx waiting for remote cal");
        next_drive_slot();
        req_drv.remote_tx_cal_done = 1'b1;
        exp_st.rx_dll_lock_req = 1'b1;
        expect_status("rx_dll_lock_req after remote_tx_cal_done");
        hold_status(6, "rx waiting for local dll lock");
        next_drive_slot();
        req_drv.local_rx_dll_lock = 1'b1;
        exp_st.rx_dll_lock = 1'b1;
        expect_status("rx_dll_lock before rx_xfer_en");
        exp_st.rx_xfer_en = 1'b1;
        expect_status("rx_xfer_en after rx_dll_lock");
        hold_status(4, "rx transfer enabled");
        next_drive_slot();
        req_drv.remote_tx_lock_req = 1'b0;
        req_drv.local_rx_lock_req  = 1'b0;
        exp_st.rx_async_rst    = 1'b0;
        exp_st.rx_dll_lock_req = 1'b0;
        exp_st.rx_dll_lock     = 1'b0;
        exp_st.rx_xfer_en      = 1'b0;
        expect_status("rx flags clear after requests drop");
        next_drive_slot();
        req_drv.remote_tx_cal_done = 1'b0;
        req_drv.local_rx_dll_lock  = 1'b0;
        hold_status(4, "rx idle");
    endtask

    task automatic test_tx_cal();
        next_drive_slot();
        req_drv.remote_rx_lock_req = 1'b1;
        req_drv.local_tx_lock_req  = 1'b1;
        exp_st.tx_async_rst   = 1'b1;
        exp_st.tx_dcc_cal_req = 1'b1;
        expect_status("tx_async_rst and tx_dcc_cal_req after tx requests");
        hold_status(6, "tx waiting for local cal");
        next_drive_slot();
        req_drv.local_tx_cal_done = 1'b1;
        exp_st.tx_dcc_cal_done = 1'b1;
        expect_status("tx_dcc_cal_done after local_tx_cal_done");
        next_drive_slot();
        req_drv.remote_rx_dll_lock = 1'b1;
        hold_status(6, "tx waiting for remote rx enable");
        next_drive_slot();
        req_drv.remote_rx_xfer_en = 1'b1;
        exp_st.tx_xfer_en = 1'b1;
        expect_status("tx_xfer_en after remote_rx_xfer_en");
        hold_status(4, "tx transfer enabled");
    endtask

    task automatic test_tx_abort();
        next_drive_slot();
        req_drv.remote_rx_lock_req = 1'b0;
        req_drv.local_tx_lock_req  = 1'b0;
        req_drv.local_tx_cal_done  = 1'b0;
        req_drv.remote_rx_dll_lock = 1'b0;
        req_drv.remote_rx_xfer_en  = 1'b0;
        exp_st.tx_async_rst    = 1'b0;
        exp_st.tx_dcc_cal_req  = 1'b0;
        exp_st.tx_dcc_cal_done = 1'b0;
        exp_st.tx_xfer_en      = 1'b0;
        expect_status("tx back to wait before abort");
        next_drive_slot();
        req_drv.remote_rx_lock_req = 1'b1;
        req_drv.local_tx_lock_req  = 1'b1;
        exp_st.tx_async_rst   = 1'b1;
        exp_st.tx_dcc_cal_req = 1'b1;
        expect_status("tx restarted");
        next_drive_slot();
        req_drv.local_tx_cal_done = 1'b1;
        exp_st.tx_dcc_cal_done = 1'b1;
        expect_status("tx waiting for remote lock");
        next_drive_slot();
        req_drv.local_tx_lock_req = 1'b0;   // abort mid-sequence
        exp_st.tx_async_rst    = 1'b0;
        exp_st.tx_dcc_cal_req  = 1'b0;
        exp_st.tx_dcc_cal_done = 1'b0;
        expect_status("tx flags clear after abort");
        next_drive_slot();
        req_drv.local_tx_cal_done = 1'b0;
        hold_status(WAIT_LIMIT, "only remote tx request high");
        next_drive_slot();
        req_drv.remote_rx_lock_req = 1'b0;
        req_drv.local_tx_lock_req  = 1'b1;
        hold_status(WAIT_LIMIT, "only local tx request high");
        next_drive_slot();
        req_drv.local_tx_lock_req = 1'b0;
    endtask

    task automatic test_config_loss();
        next_drive_slot();
        req_drv.config_done = 1'b0;
        exp_st.osc_xfer_en    = 1'b0;
        exp_st.osc_xfer_alive = 1'b0;
        expect_status("osc flags clear after config loss");
        hold_status(4, "osc in wait");
        next_drive_slot();
        req_drv.remote_tx_lock_req = 1'b1;
        req_drv.local_rx_lock_req  = 1'b1;
        req_drv.remote_rx_lock_req = 1'b1;
        req_drv.local_tx_lock_req  = 1'b1;
        hold_status(WAIT_LIMIT, "calibration requests without config");
        next_drive_slot();
        req_drv = '0;
        hold_status(4, "all idle");
    endtask

    // ========================================
    // run control
    // ========================================
    initial begin
        req_drv         = '0;
        ms_reset_n_sync = 1'b0;
        exp_st          = '0;
        err_cnt         = 0;
        chk_cnt         = 0;
        rng_state       = SEED;
        test_reset();
        test_osc_bring_up();
        test_rx_cal();
        test_tx_cal();
        test_tx_abort();
        test_config_loss();
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hdl/aib_cal_pkg.sv
hdl/aib_input_sync.sv
hdl/aib_osc_sync_fsm.sv
hdl/aib_rx_cal_fsm.sv
hdl/aib_tx_cal_fsm.sv
hdl/aib_status_reg.sv
hdl/aib_cal_top.sv
dv/aib_cal_asserts.sv
dv/aib_cal_clk_gen.sv
dv/aib_cal_tb.sv

// File: Makefile
TOP := aib_cal_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f all.f

run: compile
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir
